// File: pipe_ctrl.f
+incdir+testbench
hw/pipe_ctrl_pkg.sv
hw/stage_pipe.sv
hw/power_fsm.sv
hw/cycle_counter.sv
hw/pid_forward.sv
hw/exc_capture.sv
hw/pipe_ctrl.sv
testbench/pipe_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= pipe_ctrl_tb
FILELIST ?= pipe_ctrl.f
OBJ_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/pipe_ctrl_tb_cases.svh
// Each row gives a name, a tag count, the sleep cycles before the interrupt and the tags,
// then the expected retire count, exception count, final halt state and final PID.
localparam step_t s_nrm = '{pipe_ctrl_pkg::kind_normal, 8'h00, 32'h0};
localparam step_t s_hlt = '{pipe_ctrl_pkg::kind_halt, 8'h00, 32'h0};
localparam step_t s_slp = '{pipe_ctrl_pkg::kind_sleep, 8'h00, 32'h0};
localparam step_t s_sys = '{pipe_ctrl_pkg::kind_normal, 8'h01, 32'h0};
localparam step_t s_tlr = '{pipe_ctrl_pkg::kind_normal, 8'h82, 32'h0};
localparam step_t s_tlw = '{pipe_ctrl_pkg::kind_normal, 8'h83, 32'h0};
localparam step_t s_pid_a = '{pipe_ctrl_pkg::kind_set_pid, 8'h00, 32'h11};
localparam step_t s_pid_b = '{pipe_ctrl_pkg::kind_set_pid, 8'h00, 32'h22};

localparam int num_cases = 6;

string case_name [num_cases] = '{
    "normal_order", "halt_stop", "sleep_wake", "exc_syscall", "exc_tlb", "pid_forward"
};

int case_len [num_cases] = '{5, 5, 6, 4, 8, 3};
int case_irq [num_cases] = '{0, 0, 3, 0, 0, 0};

step_t case_steps [num_cases][8] = '{
    '{s_nrm, s_nrm, s_nrm, s_nrm, s_nrm, s_nrm, s_nrm, s_nrm},
    '{s_nrm, s_nrm, s_hlt, s_nrm, s_nrm, s_nrm, s_nrm, s_nrm},
    '{s_nrm, s_nrm, s_nrm, s_nrm, s_slp, s_nrm, s_nrm, s_nrm},
    '{s_nrm, s_sys, s_nrm, s_nrm, s_nrm, s_nrm, s_nrm, s_nrm},
    '{s_tlr, s_nrm, s_nrm, s_nrm, s_nrm, s_nrm, s_nrm, s_tlw},
    '{s_pid_a, s_pid_b, s_nrm, s_nrm, s_nrm, s_nrm, s_nrm, s_nrm}
};

int exp_retired [num_cases] = '{5, 3, 5, 2, 2, 3};
int exp_taken [num_cases] = '{0, 0, 0, 1, 2, 0};
logic exp_halted [num_cases] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
pipe_ctrl_pkg::pc_t exp_pid [num_cases] = '{32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h22};

// File: testbench/pipe_ctrl_tb.sv
`timescale 1ns/1ps

module pipe_ctrl_tb;

    localparam int num_stages = 6;
    localparam int count_width = 32;
    localparam int reset_cycles = 10;
    localparam int max_run_cycles = 48;
    localparam int st_run = 0;
    localparam int st_sleep = 1;
    localparam int st_halted = 2;

    typedef struct packed {
        pipe_ctrl_pkg::kind_e kind;
        pipe_ctrl_pkg::exc_t exc;
        pipe_ctrl_pkg::pc_t value;
    } step_t;

    `include "pipe_ctrl_tb_cases.svh"

    logic clk;
    logic arst_n;
    pipe_ctrl_pkg::tag_t issue;
    logic [15:0] interrupts;
    pipe_ctrl_pkg::retire_t retire;
    logic flush;
    logic stop;
    logic sleeping;
    logic halted;
    logic wake;
    pipe_ctrl_pkg::pc_t wake_pc;
    pipe_ctrl_pkg::pc_t pid;
    pipe_ctrl_pkg::exc_info_t exc;
    logic [count_width-1:0] count;

    // Reference model state.
    pipe_ctrl_pkg::tag_t m_st [num_stages];
    int m_state;
    int sleep_cycles;
    logic m_wake;
    pipe_ctrl_pkg::pc_t m_resume;
    pipe_ctrl_pkg::pc_t m_arch_pid;
    pipe_ctrl_pkg::pc_t m_page;
    logic [count_width-1:0] m_count;

    logic [31:0] lcg_state = 32'd92052;
    string test_name;
    int errors;
    int total_errors = 0;
    int passed = 0;

    pipe_ctrl #(
        .num_stages(num_stages),
        .count_width(count_width)
    ) pipe_ctrl_i (
        .clk(clk), .arst_n(arst_n), .issue(issue), .interrupts(interrupts),
        .retire(retire), .flush(flush), .stop(stop), .sleeping(sleeping),
        .halted(halted), .wake(wake), .wake_pc(wake_pc), .pid(pid), .exc(exc),
        .count(count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(num_cases * 64 * 8);
        $display("Watchdog expired before all tests finished.");
        $display("Test failed");
        $finish;
    end

    function automatic pipe_ctrl_pkg::pc_t next_pc();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[31:2], 2'b00};
    endfunction

    task automatic check_retire(string what, pipe_ctrl_pkg::retire_t e,
                                pipe_ctrl_pkg::retire_t a);
        if (a !== e) begin
            $display("mismatch %s %s: expected %h actual %h", test_name, what, e, a);
            errors++;
        end
    endtask

    task automatic check_exc(string what, pipe_ctrl_pkg::exc_info_t e,
                             pipe_ctrl_pkg::exc_info_t a);
        if (a !== e) begin
            $display("mismatch %s %s: expected %h actual %h", test_name, what, e, a);
            errors++;
        end
    endtask

    task automatic check_pc(string what, pipe_ctrl_pkg::pc_t e, pipe_ctrl_pkg::pc_t a);
        if (a !== e) begin
            $display("mismatch %s %s: expected %h actual %h", test_name, what, e, a);
            errors++;
        end
    endtask

    task automatic check_flag(string what, logic e, logic a);
        if (a !== e) begin
            $display("mismatch %s %s: expected %b actual %b", test_name, what, e, a);
            errors++;
        end
    endtask

    task automatic check_count(string what, logic [count_width-1:0] e,
                               logic [count_width-1:0] a);
        if (a !== e) begin
            $display("mismatch %s %s: expected %0d actual %0d", test_name, what, e, a);
            errors++;
        end
    endtask

    function automatic logic exc_in_flight();
        logic live;
        live = 1'b0;
        foreach (m_st[i]) begin
            if (m_st[i].valid && m_st[i].exc != 8'h00) begin
                live = 1'b1;
            end
        end
        return live;
    endfunction

    function automatic logic halt_in_flight();
        logic seen;
        seen = 1'b0;
        foreach (m_st[i]) begin
            if (m_st[i].valid && m_st[i].kind == pipe_ctrl_pkg::kind_halt) begin
                seen = 1'b1;
            end
        end
        return seen && !exc_in_flight();
    endfunction

    function automatic logic sleep_in_exec();
        return m_st[1].valid && m_st[1].kind == pipe_ctrl_pkg::kind_sleep;
    endfunction

    function automatic logic pipe_empty();
        logic empty;
        empty = 1'b1;
        foreach (m_st[i]) begin
            if (m_st[i].valid) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    task automatic reset_model();
        foreach (m_st[i]) begin
            m_st[i] = '0;
        end
        m_state = st_run;
        sleep_cycles = 0;
        m_wake = 1'b0;
        m_arch_pid = '0;
        m_page = '0;
        m_count = '0;
    endtask

    task automatic check_cycle();
        pipe_ctrl_pkg::retire_t e_ret;
        pipe_ctrl_pkg::exc_info_t e_exc;
        pipe_ctrl_pkg::tag_t wb;
        pipe_ctrl_pkg::pc_t e_pid;
        logic frz;
        logic tlb;
        logic found;
        wb = m_st[num_stages-1];
        frz = m_state != st_run;
        e_ret.valid = wb.valid && !frz;
        e_ret.pc = wb.pc;
        tlb = wb.valid && (wb.exc == 8'h82 || wb.exc == 8'h83);
        e_exc.taken = wb.valid && wb.exc != 8'h00 && !frz;
        e_exc.epc = (wb.exc == 8'h01) ? wb.pc + 32'd4 : wb.pc;
        e_exc.code = wb.exc;
        e_exc.fault_page = tlb ? wb.pc >> 12 : m_page;
        // Youngest in-flight set-PID sits at the lowest stage index.
        e_pid = m_arch_pid;
        found = 1'b0;
        for (int i = 1; i < num_stages; i++) begin
            if (!found && m_st[i].valid && m_st[i].kind == pipe_ctrl_pkg::kind_set_pid) begin
                e_pid = m_st[i].value;
                found = 1'b1;
            end
        end
        check_retire("retire", e_ret, retire);
        check_exc("exc", e_exc, exc);
        check_pc("pid", e_pid, pid);
        check_flag("flush", exc_in_flight() || sleep_in_exec(), flush);
        check_flag("stop", halt_in_flight() || frz, stop);
        check_flag("sleeping", m_state == st_sleep, sleeping);
        check_flag("halted", m_state == st_halted, halted);
        check_flag("wake", m_wake, wake);
        if (m_wake) begin
            check_pc("wake_pc", m_resume, wake_pc);
        end
        check_count("count", m_count, count);
    endtask

    task automatic model_step(pipe_ctrl_pkg::tag_t t, logic irq);
        pipe_ctrl_pkg::tag_t wb;
        logic frz;
        logic sleep_fl;
        logic accept;
        int old_state;
        wb = m_st[num_stages-1];
        old_state = m_state;
        frz = m_state != st_run;
        sleep_fl = sleep_in_exec();
        accept = t.valid && !(halt_in_flight() || frz) && !(exc_in_flight() || sleep_fl);
        if (old_state == st_run) begin
            if (wb.valid && wb.kind == pipe_ctrl_pkg::kind_halt) begin
                m_state = st_halted;
            end else if (sleep_fl) begin
                m_state = st_sleep;
                m_resume = m_st[1].pc + 32'd4;
                sleep_cycles = 0;
            end
        end else if (old_state == st_sleep) begin
            sleep_cycles++;
            if (irq) begin
                m_state = st_run;
            end
        end
        m_wake = old_state == st_sleep && irq;
        if (!frz) begin
            if (wb.valid && wb.kind == pipe_ctrl_pkg::kind_set_pid) begin
                m_arch_pid = wb.value;
            end
            if (wb.valid && (wb.exc == 8'h82 || wb.exc == 8'h83)) begin
                m_page = wb.pc >> 12;
            end
            for (int i = num_stages - 1; i >= 2; i--) begin
                m_st[i] = m_st[i-1];
            end
            m_st[1] = sleep_fl ? '0 : m_st[0];
            m_st[0] = accept ? t : '0;
        end
        if (old_state != st_halted) begin
            m_count++;
        end
    endtask

    task automatic run_case(int r);
        pipe_ctrl_pkg::tag_t t;
        int idx;
        int cycle;
        int halt_hold;
        int n_ret;
        int n_taken;
        logic done;
        test_name = case_name[r];
        errors = 0;
        issue = '0;
        interrupts = '0;
        arst_n = 1'b0;
        reset_model();
        repeat (reset_cycles) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idx = 0;
        cycle = 0;
        halt_hold = 0;
        n_ret = 0;
        n_taken = 0;
        done = 1'b0;
        while (!done) begin
            t = '0;
            if (idx < case_len[r]) begin
                t.valid = 1'b1;
                t.kind = case_steps[r][idx].kind;
                t.exc = case_steps[r][idx].exc;
                t.pc = next_pc();
                t.value = case_steps[r][idx].value;
                idx++;
            end
            issue = t;
            interrupts = (m_state == st_sleep && sleep_cycles >= case_irq[r]) ? 16'h0004 : '0;
            #4;
            check_cycle();
            n_ret += int'(retire.valid === 1'b1);
            n_taken += int'(exc.taken === 1'b1);
            model_step(t, interrupts != '0);
            @(posedge clk);
            #1;
            cycle++;
            if (m_state == st_halted) begin
                halt_hold++;
            end
            if (halt_hold > 4 ||
                (idx >= case_len[r] && pipe_empty() && m_state == st_run && !m_wake)) begin
                done = 1'b1;
            end else if (cycle >= max_run_cycles) begin
                $display("%s: pipeline did not drain within %0d cycles", test_name, cycle);
                errors++;
                done = 1'b1;
            end
        end
        check_count("retired", count_width'(exp_retired[r]), count_width'(n_ret));
        check_count("exceptions", count_width'(exp_taken[r]), count_width'(n_taken));
        check_flag("final halted", exp_halted[r], halted);
        check_pc("final pid", exp_pid[r], pid);
        $display("%s %s (%0d errors)", (errors == 0) ? "PASS" : "FAIL", test_name, errors);
        total_errors += errors;
        passed += int'(errors == 0);
    endtask

    initial begin
        arst_n = 1'b0;
        issue = '0;
        interrupts = '0;
        for (int r = 0; r < num_cases; r++) begin
            run_case(r);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 num_cases, passed, num_cases - passed, total_errors);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: hw/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl #(
    parameter int num_stages = 6,
    parameter int count_width = 32
) (
    input logic clk,
    input logic arst_n,
    input pipe_ctrl_pkg::tag_t issue,
    input logic [15:0] interrupts,
    output pipe_ctrl_pkg::retire_t retire,
    output logic flush,
    output logic stop,
    output logic sleeping,
    output logic halted,
    output logic wake,
    output pipe_ctrl_pkg::pc_t wake_pc,
    output pipe_ctrl_pkg::pc_t pid,
    output pipe_ctrl_pkg::exc_info_t exc,
    output logic [count_width-1:0] count
);

    pipe_ctrl_pkg::tag_t [num_stages-1:0] stages;
    logic frozen;

    stage_pipe #(
        .num_stages(num_stages)
    ) stage_pipe_i (
        .clk(clk),
        .arst_n(arst_n),
        .issue(issue),
        .frozen(frozen),
        .stages(stages),
        .retire(retire),
        .flush(flush),
        .halt_pending(),
        .stop(stop)
    );

    // Stage 1 is execute, the last stage is writeback.
    power_fsm power_fsm_i (
        .clk(clk),
        .arst_n(arst_n),
        .exec_tag(stages[1]),
        .wb_tag(stages[num_stages-1]),
        .interrupts(interrupts),
        .sleeping(sleeping),
        .halted(halted),
        .frozen(frozen),
        .wake(wake),
        .wake_pc(wake_pc)
    );

    cycle_counter #(
        .count_width(count_width)
    ) cycle_counter_i (
        .clk(clk),
        .arst_n(arst_n),
        .halted(halted),
        .count(count)
    );

    pid_forward #(
        .num_stages(num_stages)
    ) pid_forward_i (
        .clk(clk),
        .arst_n(arst_n),
        .stages(stages),
        .frozen(frozen),
        .pid(pid)
    );

    exc_capture #(
        .num_stages(num_stages)
    ) exc_capture_i (
        .clk(clk),
        .arst_n(arst_n),
        .wb_tag(stages[num_stages-1]),
        .frozen(frozen),
        .exc(exc)
    );

endmodule

// File: hw/exc_capture.sv
`timescale 1ns/1ps

module exc_capture #(
    parameter int num_stages = 6
) (
    input logic clk,
    input logic arst_n,
    input pipe_ctrl_pkg::tag_t wb_tag,
    input logic frozen,
    output pipe_ctrl_pkg::exc_info_t exc
);

    logic wb_exc;
    logic tlb_fault;
    pipe_ctrl_pkg::pc_t live_page;
    pipe_ctrl_pkg::pc_t page_q;

    // Writeback must sit behind both decode and execute.
    if (num_stages < 3) begin : g_depth_check
        $error("exc_capture expects at least three pipeline stages");
    end

    assign wb_exc = wb_tag.valid && wb_tag.exc != '0;
    assign tlb_fault = wb_exc &&
        (wb_tag.exc == pipe_ctrl_pkg::exc_tlb_read ||
         wb_tag.exc == pipe_ctrl_pkg::exc_tlb_write);
    assign live_page = wb_tag.pc >> pipe_ctrl_pkg::page_bits;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            page_q <= '0;
        end else if (!frozen && tlb_fault) begin
            page_q <= live_page;
        end
    end

    assign exc.taken = wb_exc && !frozen;
    // Syscall resumes past itself, faults replay the instruction.
    assign exc.epc = (wb_tag.exc == pipe_ctrl_pkg::exc_syscall) ?
        wb_tag.pc + pipe_ctrl_pkg::pc_t'(pipe_ctrl_pkg::instr_bytes) : wb_tag.pc;
    assign exc.code = wb_tag.exc;
    assign exc.fault_page = tlb_fault ? live_page : page_q;

    a_taken_code: assert property (
        @(posedge clk) disable iff (!arst_n)
        exc.taken |-> exc.code != '0
    );

endmodule

// File: hw/pid_forward.sv
`timescale 1ns/1ps

module pid_forward #(
    parameter int num_stages = 6
) (
    input logic clk,
    input logic arst_n,
    input pipe_ctrl_pkg::tag_t [num_stages-1:0] stages,
    input logic frozen,
    output pipe_ctrl_pkg::pc_t pid
);

    pipe_ctrl_pkg::pc_t arch_pid;
    pipe_ctrl_pkg::tag_t wb_tag;
    logic wb_set_pid;

    assign wb_tag = stages[num_stages-1];
    assign wb_set_pid = wb_tag.valid && wb_tag.kind == pipe_ctrl_pkg::kind_set_pid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arch_pid <= '0;
        end else if (!frozen && wb_set_pid) begin
            arch_pid <= wb_tag.value;
        end
    end

    // Walk oldest to youngest so the youngest set-PID overrides.
    always_comb begin
        pid = arch_pid;
        for (int i = num_stages - 1; i >= 1; i--) begin
            if (stages[i].valid && stages[i].kind == pipe_ctrl_pkg::kind_set_pid) begin
                pid = stages[i].value;
            end
        end
    end

endmodule

// File: hw/cycle_counter.sv
`timescale 1ns/1ps

module cycle_counter #(
    parameter int count_width = 32
) (
    input logic clk,
    input logic arst_n,
    input logic halted,
    output logic [count_width-1:0] count
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (!halted) begin
            count <= count + 1'b1;
        end
    end

    a_count_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        halted |=> $stable(count)
    );

endmodule

// File: hw/power_fsm.sv
`timescale 1ns/1ps

module power_fsm (
    input logic clk,
    input logic arst_n,
    input pipe_ctrl_pkg::tag_t exec_tag,
    input pipe_ctrl_pkg::tag_t wb_tag,
    input logic [15:0] interrupts,
    output logic sleeping,
    output logic halted,
    output logic frozen,
    output logic wake,
    output pipe_ctrl_pkg::pc_t wake_pc
);

    typedef enum logic [1:0] {
        st_run = 2'd0,
        st_sleep = 2'd1,
        st_halted = 2'd2
    } state_e;

    state_e state;
    state_e state_next;
    pipe_ctrl_pkg::pc_t resume_pc;
    logic wake_q;
    logic halt_in_wb;
    logic sleep_in_exec;
    logic irq;

    assign halt_in_wb = wb_tag.valid && wb_tag.kind == pipe_ctrl_pkg::kind_halt;
    assign sleep_in_exec = exec_tag.valid && exec_tag.kind == pipe_ctrl_pkg::kind_sleep;
    assign irq = interrupts != '0;

    // Halt wins over a sleep entering at the same edge.
    always_comb begin
        state_next = state;
        case (state)
            st_run: begin
                if (halt_in_wb) begin
                    state_next = st_halted;
                end else if (sleep_in_exec) begin
                    state_next = st_sleep;
                end
            end
            st_sleep: begin
                if (irq) begin
                    state_next = st_run;
                end
            end
            default: state_next = st_halted;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_run;
            wake_q <= 1'b0;
        end else begin
            state <= state_next;
            wake_q <= state == st_sleep && irq;
        end
    end

    // Resume point is the instruction after the sleep.
    always_ff @(posedge clk) begin
        if (state == st_run && state_next == st_sleep) begin
            resume_pc <= exec_tag.pc + pipe_ctrl_pkg::pc_t'(pipe_ctrl_pkg::instr_bytes);
        end
    end

    assign sleeping = state == st_sleep;
    assign halted = state == st_halted;
    assign frozen = state != st_run;
    assign wake = wake_q;
    assign wake_pc = resume_pc;

    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!arst_n)
        halted |=> halted
    );

endmodule

// File: hw/stage_pipe.sv
`timescale 1ns/1ps

module stage_pipe #(
    parameter int num_stages = 6
) (
    input logic clk,
    input logic arst_n,
    input pipe_ctrl_pkg::tag_t issue,
    input logic frozen,
    output pipe_ctrl_pkg::tag_t [num_stages-1:0] stages,
    output pipe_ctrl_pkg::retire_t retire,
    output logic flush,
    output logic halt_pending,
    output logic stop
);

    logic exc_live;
    logic halt_seen;
    logic sleep_flush;
    logic accept;

    // Scan every live stage for exceptions and halts.
    always_comb begin
        exc_live = 1'b0;
        halt_seen = 1'b0;
        for (int i = 0; i < num_stages; i++) begin
            if (stages[i].valid && stages[i].exc != '0) begin
                exc_live = 1'b1;
            end
            if (stages[i].valid && stages[i].kind == pipe_ctrl_pkg::kind_halt) begin
                halt_seen = 1'b1;
            end
        end
    end

    assign sleep_flush = stages[1].valid && stages[1].kind == pipe_ctrl_pkg::kind_sleep;
    assign flush = exc_live || sleep_flush;
    assign halt_pending = halt_seen && !exc_live;
    assign stop = halt_pending || frozen;
    assign accept = issue.valid && !stop && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stages <= '0;
        end else if (!frozen) begin
            stages[0] <= accept ? issue : '0;
            // Sleep in execute kills the decode tag behind it.
            stages[1] <= sleep_flush ? '0 : stages[0];
            for (int i = 2; i < num_stages; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // A tag is reported only on the cycle it actually leaves writeback.
    assign retire.valid = stages[num_stages-1].valid && !frozen;
    assign retire.pc = stages[num_stages-1].pc;

    a_frozen_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        frozen |=> $stable(stages)
    );

endmodule

// File: hw/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    localparam int xlen = 32;
    localparam int instr_bytes = 4;
    localparam int page_bits = 12;

    typedef logic [xlen-1:0] pc_t;

    // Zero means the instruction carries no exception.
    typedef logic [7:0] exc_t;

    localparam exc_t exc_syscall = 8'h01;
    localparam exc_t exc_tlb_read = 8'h82;
    localparam exc_t exc_tlb_write = 8'h83;

    typedef enum logic [1:0] {
        kind_normal = 2'd0,
        kind_halt = 2'd1,
        kind_sleep = 2'd2,
        kind_set_pid = 2'd3
    } kind_e;

    // Per-instruction tag carried down the pipeline.
    typedef struct packed {
        logic valid;
        kind_e kind;
        exc_t exc;
        pc_t pc;
        pc_t value;
    } tag_t;

    typedef struct packed {
        logic valid;
        pc_t pc;
    } retire_t;

    typedef struct packed {
        logic taken;
        pc_t epc;
        exc_t code;
        pc_t fault_page;
    } exc_info_t;

endpackage
